// ==== include/mmu_consts.svh ====
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

//////////////////////////////
// Sv32 field widths
//////////////////////////////
`define VPN_W 20
`define PPN_W 22
`define PA_W 34

// PTE flag positions.
`define PTE_V 0
`define PTE_R 1
`define PTE_W 2
`define PTE_X 3
`define PTE_U 4
`define PTE_G 5

`define RQID_W 2

//////////////////////////////
// default TLB geometry
//////////////////////////////
`define ITLB_SIZE 8
`define DTLB_SIZE 16
`define TLB_ASSOC 4

`endif

// ==== src/mmuPkg.sv ====
`include "mmu_consts.svh"

package mmuPkg;

    // one lookup port of a TLB.
    typedef struct packed {
        logic valid;
        logic [`VPN_W-1:0] vpn;
    } TlbReq;

    // rwx holds R in bit 0, W in bit 1 and X in bit 2, as in the PTE.
    typedef struct packed {
        logic hit;
        logic [19:0] ppn;
        logic [2:0] rwx;
        logic user;
        logic isSuper;
        logic pageFault;
        logic accessFault;
    } TlbRes;

    //////////////////////////////
    // walker result
    //////////////////////////////

    // Broadcast to both TLBs. The full 22 bit PPN is kept so that each
    // receiver can flag the access fault from the two top bits.
    typedef struct packed {
        logic valid;                  // one cycle pulse.
        logic busy;                   // level, high while a walk runs.
        logic [`RQID_W-1:0] rqId;
        logic [`VPN_W-1:0] vpn;
        logic [`PPN_W-1:0] ppn;
        logic [2:0] rwx;
        logic user;
        logic globl;
        logic isSuperPage;
        logic pageFault;
    } PageWalkRes;

    // rqId 0 belongs to instruction fetch, all others to the AGUs.
    localparam logic [`RQID_W-1:0] IFETCH_RQID = '0;

endpackage

// ==== src/pageWalkBus.sv ====
`include "mmu_consts.svh"

interface pageWalkBus import mmuPkg::*; ();

    PageWalkRes res;

    // physical pages above the 32 bit range are not backed by anything.
    logic accessFault;

    assign accessFault = res.ppn[`PPN_W-1:20] != '0;

    //////////////////////////////
    // views
    //////////////////////////////

    modport walker (
        output res,
        input  accessFault
    );

    // Both TLBs and the top level only listen.
    modport tlb (
        input res,
        input accessFault
    );

endinterface

// ==== src/tlb.sv ====
`include "mmu_consts.svh"

module tlb import mmuPkg::*; #(
    parameter int NUM_RQ = 1,
    parameter int SIZE = `ITLB_SIZE,
    parameter int ASSOC = `TLB_ASSOC,
    parameter bit IS_IFETCH = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    pageWalkBus.tlb pw,
    input  TlbReq reqs [NUM_RQ],
    output TlbRes res [NUM_RQ]
);

    localparam int LEN = SIZE / ASSOC;
    localparam int IDX_W = $clog2(LEN);
    localparam int WAY_W = $clog2(ASSOC);
    localparam int TAG_W = `VPN_W - IDX_W;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [19:0] ppn;
        logic [2:0] rwx;
        logic user;
        logic isSuper;
        logic pageFault;
        logic accessFault;
    } TlbEntry;

    TlbEntry store [LEN][ASSOC];
    logic [ASSOC-1:0] entryValid [LEN];
    logic [WAY_W-1:0] victim [LEN];      // round robin pointer per set.
    logic [LEN-1:0] inc;
    logic [IDX_W-1:0] setIdx [NUM_RQ];
    logic [ASSOC-1:0] hitWays [NUM_RQ];

    logic dropWalk;                      // set by a fence, eats the walk in flight.
    logic sideMatch;
    logic fillEn;
    logic [IDX_W-1:0] fillSet;
    TlbEntry fillEntry;

    // A superpage only compares the top ten VPN bits.
    function automatic logic tagMatch(input TlbEntry e, input logic [`VPN_W-1:0] vpn);
        if (e.isSuper)
            return e.tag[TAG_W-1 -: 10] == vpn[19:10];
        return e.tag == vpn[`VPN_W-1:IDX_W];
    endfunction

    //////////////////////////////
    // lookup
    //////////////////////////////

    always_comb begin
        TlbEntry e;
        inc = '0;
        for (int i = 0; i < NUM_RQ; i++) begin
            setIdx[i] = reqs[i].vpn[IDX_W-1:0];
            hitWays[i] = '0;
            res[i] = '0;
            for (int j = 0; j < ASSOC; j++) begin
                e = store[setIdx[i]][j];
                if (reqs[i].valid && entryValid[setIdx[i]][j] && tagMatch(e, reqs[i].vpn)) begin
                    hitWays[i][j] = 1'b1;
                    res[i].hit = 1'b1;
                    res[i].ppn = e.isSuper ? {e.ppn[19:10], reqs[i].vpn[9:0]} : e.ppn;
                    res[i].rwx = e.rwx;
                    res[i].user = e.user;
                    res[i].isSuper = e.isSuper;
                    res[i].pageFault = e.pageFault;
                    res[i].accessFault = e.accessFault;
                    if (victim[setIdx[i]] == WAY_W'(j))
                        inc[setIdx[i]] = 1'b1;   // the pointer moves past a way in use.
                end
            end
        end
    end

    //////////////////////////////
    // fill
    //////////////////////////////

    assign sideMatch = IS_IFETCH ? (pw.res.rqId == IFETCH_RQID) : (pw.res.rqId != IFETCH_RQID);
    assign fillEn = pw.res.valid && !dropWalk && sideMatch;
    assign fillSet = pw.res.vpn[IDX_W-1:0];

    always_comb begin
        fillEntry.tag = pw.res.vpn[`VPN_W-1:IDX_W];
        fillEntry.ppn = pw.res.ppn[19:0];
        fillEntry.rwx = pw.res.rwx;
        fillEntry.user = pw.res.user;
        fillEntry.isSuper = pw.res.isSuperPage;
        fillEntry.pageFault = pw.res.pageFault;
        fillEntry.accessFault = pw.accessFault;
    end

    always_ff @(posedge clk) begin
        if (fillEn)
            store[fillSet][victim[fillSet]] <= fillEntry;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dropWalk <= 1'b0;
            for (int s = 0; s < LEN; s++) begin
                entryValid[s] <= '0;
                victim[s] <= '0;
            end
        end else if (clear) begin
            // an sfence.vma also makes the walk in progress stale.
            dropWalk <= 1'b1;
            for (int s = 0; s < LEN; s++)
                entryValid[s] <= '0;
        end else begin
            if (dropWalk && !pw.res.busy)
                dropWalk <= 1'b0;
            if (fillEn)
                entryValid[fillSet][victim[fillSet]] <= 1'b1;
            for (int s = 0; s < LEN; s++)
                if (inc[s]) victim[s] <= victim[s] + 1'b1;
        end
    end

    // Two ways with the same page only appear if the core walked it twice.
    for (genvar p = 0; p < NUM_RQ; p++) begin : gOneHit
        assert property (@(posedge clk) disable iff (rst) $onehot0(hitWays[p]));
    end

endmodule

// ==== src/pageWalker.sv ====
`include "mmu_consts.svh"

module pageWalker import mmuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [`PPN_W-1:0] rootPpn,

    input  logic walkReqValid,
    input  logic [`VPN_W-1:0] walkReqVpn,
    input  logic [`RQID_W-1:0] walkReqId,

    output logic memReq,
    output logic [`PA_W-1:0] memAddr,
    input  logic memRespValid,
    input  logic [31:0] memRespData,

    pageWalkBus.walker pw
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_L1,
        WAIT_L0,
        DONE
    } WalkState;

    WalkState state;
    logic [`VPN_W-1:0] curVpn;
    logic [`RQID_W-1:0] curId;
    PageWalkRes result;

    logic [`PPN_W-1:0] ptePpn;
    logic [2:0] pteRwx;
    logic pteLeaf;
    logic pteBad;

    //////////////////////////////
    // PTE decode
    //////////////////////////////

    assign ptePpn = memRespData[31:10];
    assign pteRwx = memRespData[`PTE_X:`PTE_R];
    assign pteLeaf = memRespData[`PTE_R] | memRespData[`PTE_X];
    // writable without readable is a reserved encoding.
    assign pteBad = !memRespData[`PTE_V] || (memRespData[`PTE_W] && !memRespData[`PTE_R]);

    function automatic PageWalkRes finish(input logic superPage, input logic fault);
        PageWalkRes r;
        r.valid = 1'b1;
        r.busy = 1'b1;
        r.rqId = curId;
        r.vpn = curVpn;
        r.ppn = ptePpn;
        r.rwx = pteRwx;
        r.user = memRespData[`PTE_U];
        r.globl = memRespData[`PTE_G];
        r.isSuperPage = superPage;
        r.pageFault = fault;
        return r;
    endfunction

    //////////////////////////////
    // walk FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            memReq <= 1'b0;
            result.valid <= 1'b0;
            result.busy <= 1'b0;
        end else begin
            memReq <= 1'b0;
            result.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (walkReqValid) begin
                        curVpn <= walkReqVpn;
                        curId <= walkReqId;
                        memReq <= 1'b1;
                        memAddr <= {rootPpn, walkReqVpn[19:10], 2'b00};
                        result.busy <= 1'b1;
                        state <= WAIT_L1;
                    end
                end
                WAIT_L1: begin
                    if (memRespValid) begin
                        if (pteBad) begin
                            result <= finish(1'b1, 1'b1);
                            state <= DONE;
                        end else if (pteLeaf) begin
                            // a superpage must be aligned to 4 MiB.
                            result <= finish(1'b1, ptePpn[9:0] != '0);
                            state <= DONE;
                        end else begin
                            memReq <= 1'b1;
                            memAddr <= {ptePpn, curVpn[9:0], 2'b00};
                            state <= WAIT_L0;
                        end
                    end
                end
                WAIT_L0: begin
                    if (memRespValid) begin
                        result <= finish(1'b0, pteBad || !pteLeaf);
                        state <= DONE;
                    end
                end
                DONE: begin
                    result.busy <= 1'b0;    // the result pulse has gone out.
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign pw.res = result;

    // The memory only answers reads this walker has issued.
    assert property (@(posedge clk) disable iff (rst)
        memRespValid |-> (state == WAIT_L1 || state == WAIT_L0));

endmodule

// ==== src/mmuTop.sv ====
`include "mmu_consts.svh"

module mmuTop import mmuPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic [`PPN_W-1:0] rootPpn,

    input  logic walkReqValid,
    input  logic [`VPN_W-1:0] walkReqVpn,
    input  logic [`RQID_W-1:0] walkReqId,
    output logic walkBusy,
    output logic walkDoneValid,
    output logic [`RQID_W-1:0] walkDoneId,
    output logic walkDonePageFault,
    output logic walkDoneAccessFault,

    output logic memReq,
    output logic [`PA_W-1:0] memAddr,
    input  logic memRespValid,
    input  logic [31:0] memRespData,

    input  logic iValid,
    input  logic [`VPN_W-1:0] iVpn,
    output logic iHit,
    output logic [19:0] iPpn,
    output logic [2:0] iRwx,
    output logic iUser,
    output logic iSuper,
    output logic iPageFault,
    output logic iAccessFault,

    // index 0 and 1 are the two AGUs.
    input  logic [1:0] dValid,
    input  logic [1:0][`VPN_W-1:0] dVpn,
    output logic [1:0] dHit,
    output logic [1:0][19:0] dPpn,
    output logic [1:0][2:0] dRwx,
    output logic [1:0] dUser,
    output logic [1:0] dSuper,
    output logic [1:0] dPageFault,
    output logic [1:0] dAccessFault
);

    localparam int D_PORTS = 2;

    TlbReq iReq [1];
    TlbRes iRes [1];
    TlbReq dReq [D_PORTS];
    TlbRes dRes [D_PORTS];

    pageWalkBus pwBus ();

    pageWalker walker (
        .clk(clk),
        .rst(rst),
        .rootPpn(rootPpn),
        .walkReqValid(walkReqValid),
        .walkReqVpn(walkReqVpn),
        .walkReqId(walkReqId),
        .memReq(memReq),
        .memAddr(memAddr),
        .memRespValid(memRespValid),
        .memRespData(memRespData),
        .pw(pwBus)
    );

    tlb #(.NUM_RQ(1), .SIZE(`ITLB_SIZE), .ASSOC(`TLB_ASSOC), .IS_IFETCH(1'b1)) itlb (
        .clk(clk), .rst(rst), .clear(clear), .pw(pwBus), .reqs(iReq), .res(iRes)
    );

    tlb #(.NUM_RQ(D_PORTS), .SIZE(`DTLB_SIZE), .ASSOC(`TLB_ASSOC), .IS_IFETCH(1'b0)) dtlb (
        .clk(clk), .rst(rst), .clear(clear), .pw(pwBus), .reqs(dReq), .res(dRes)
    );

    //////////////////////////////
    // port packing
    //////////////////////////////

    assign walkBusy = pwBus.res.busy;
    assign walkDoneValid = pwBus.res.valid;
    assign walkDoneId = pwBus.res.rqId;
    assign walkDonePageFault = pwBus.res.pageFault;
    assign walkDoneAccessFault = pwBus.accessFault;

    assign iReq[0] = '{valid: iValid, vpn: iVpn};
    assign {iHit, iPpn, iRwx, iUser, iSuper, iPageFault, iAccessFault} = iRes[0];

    for (genvar p = 0; p < D_PORTS; p++) begin : gDPort
        assign dReq[p] = '{valid: dValid[p], vpn: dVpn[p]};
        assign dHit[p] = dRes[p].hit;
        assign dPpn[p] = dRes[p].ppn;
        assign dRwx[p] = dRes[p].rwx;
        assign dUser[p] = dRes[p].user;
        assign dSuper[p] = dRes[p].isSuper;
        assign dPageFault[p] = dRes[p].pageFault;
        assign dAccessFault[p] = dRes[p].accessFault;
    end

endmodule

// ==== testbench/pageTableMem.sv ====
`include "mmu_consts.svh"

module pageTableMem #(
    parameter logic [31:0] SEED = 32'hc207_0183,
    parameter logic [`PPN_W-1:0] ROOT = 22'd1
) (
    input  logic clk,
    input  logic rst,
    input  logic memReq,
    input  logic [`PA_W-1:0] memAddr,
    output logic memRespValid,
    output logic [31:0] memRespData
);

    // the level-one entry kind is picked by k mod 4, with k = VPN[19:10].
    function automatic logic [31:0] pteAt(input logic [`PA_W-1:0] addr);
        logic [`PPN_W-1:0] page;
        logic [9:0] idx;
        logic [9:0] k;
        logic [19:0] vpn;
        page = addr[`PA_W-1:12];
        idx = addr[11:2];
        if (page == ROOT) begin
            k = idx;
            case (k[1:0])
                2'd0: return {22'd16 + 22'(k), 10'h001};        // pointer to page 16+k.
                2'd1: return {2'b00, k, 10'h000, 10'h00B};      // superpage, r-x.
                2'd2: return 32'h0;
                default: return {2'b01, k, 10'h000, 10'h007};   // ppn bit 20 set, rw-.
            endcase
        end
        if (page >= 22'd16 && page < 22'd1040) begin
            k = 10'(page - 22'd16);
            vpn = {k, idx};
            return {2'b00, vpn + 20'h01000, 10'h017};           // user leaf, rw-.
        end
        return 32'h0;
    endfunction

    //////////////////////////////
    // response with random latency
    //////////////////////////////

    initial begin
        int latency;
        logic [`PA_W-1:0] pendAddr;
        bit pending;
        void'($urandom(SEED));
        memRespValid = 1'b0;
        memRespData = '0;
        pending = 1'b0;
        latency = 0;
        pendAddr = '0;
        forever begin
            @(negedge clk);
            memRespValid = 1'b0;
            if (rst) begin
                pending = 1'b0;
            end else if (memReq && !pending) begin
                pending = 1'b1;
                pendAddr = memAddr;
                latency = int'($urandom % 6) + 1;   // 1 to 6 cycles.
            end else if (pending) begin
                latency--;
                if (latency == 0) begin
                    memRespValid = 1'b1;
                    memRespData = pteAt(pendAddr);
                    pending = 1'b0;
                end
            end
        end
    end

endmodule

// ==== testbench/mmuTb.sv ====
`include "mmu_consts.svh"

module mmuTb;

    localparam int TIMEOUT = 200;
    localparam int NSTEPS = 38;

    typedef enum logic [2:0] {
        OpWalk,
        OpClearWalk,
        OpILook,
        OpDLook,
        OpClear
    } StepOp;

    // walk rows use id, pf and af. lookup rows use hit and the translation.
    typedef struct packed {
        StepOp op;
        logic [19:0] vpn;
        logic [1:0] id;
        logic hit;
        logic [19:0] ppn;
        logic [2:0] rwx;
        logic user;
        logic sup;
        logic pf;
        logic af;
    } Step;

    logic clk;
    logic rst;
    logic clear;
    logic [`PPN_W-1:0] rootPpn;
    logic walkReqValid;
    logic [`VPN_W-1:0] walkReqVpn;
    logic [`RQID_W-1:0] walkReqId;
    logic walkBusy;
    logic walkDoneValid;
    logic [`RQID_W-1:0] walkDoneId;
    logic walkDonePageFault;
    logic walkDoneAccessFault;
    logic memReq;
    logic [`PA_W-1:0] memAddr;
    logic memRespValid;
    logic [31:0] memRespData;
    logic iValid;
    logic [`VPN_W-1:0] iVpn;
    logic iHit;
    logic [19:0] iPpn;
    logic [2:0] iRwx;
    logic iUser;
    logic iSuper;
    logic iPageFault;
    logic iAccessFault;
    logic [1:0] dValid;
    logic [1:0][`VPN_W-1:0] dVpn;
    logic [1:0] dHit;
    logic [1:0][19:0] dPpn;
    logic [1:0][2:0] dRwx;
    logic [1:0] dUser;
    logic [1:0] dSuper;
    logic [1:0] dPageFault;
    logic [1:0] dAccessFault;

    int errors = 0;
    int checks = 0;

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    Step steps [NSTEPS] = '{
        '{OpILook, 20'h00005, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h00005, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpWalk, 20'h01123, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpILook, 20'h01123, 2'd0, 1'b1, 20'h02123, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h01123, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpWalk, 20'h020AA, 2'd1, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h020AA, 2'd0, 1'b1, 20'h030AA, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OpILook, 20'h020AA, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        // superpage k=5, looked up in the same set elsewhere in the region.
        '{OpWalk, 20'h01410, 2'd2, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h017FC, 2'd0, 1'b1, 20'h017FC, 3'd5, 1'b0, 1'b1, 1'b0, 1'b0},
        '{OpDLook, 20'h01400, 2'd0, 1'b1, 20'h01400, 3'd5, 1'b0, 1'b1, 1'b0, 1'b0},
        '{OpILook, 20'h017FC, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpWalk, 20'h01804, 2'd1, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b1, 1'b0},
        '{OpDLook, 20'h01804, 2'd0, 1'b1, 20'h00004, 3'd0, 1'b0, 1'b1, 1'b1, 1'b0},
        '{OpWalk, 20'h01C08, 2'd3, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{OpDLook, 20'h01C08, 2'd0, 1'b1, 20'h01C08, 3'd3, 1'b0, 1'b1, 1'b0, 1'b1},
        '{OpClear, 20'h00000, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpILook, 20'h01123, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h020AA, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h01400, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        // replacement in data TLB set 3.
        '{OpWalk, 20'h00003, 2'd1, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h00003, 2'd0, 1'b1, 20'h01003, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OpWalk, 20'h00007, 2'd1, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h00003, 2'd0, 1'b1, 20'h01003, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OpWalk, 20'h0000B, 2'd1, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h00007, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h00003, 2'd0, 1'b1, 20'h01003, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h0000B, 2'd0, 1'b1, 20'h0100B, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OpClear, 20'h00000, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h00003, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpClearWalk, 20'h00013, 2'd1, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h00013, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpClearWalk, 20'h00013, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpILook, 20'h00013, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpWalk, 20'h00013, 2'd1, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpDLook, 20'h00013, 2'd0, 1'b1, 20'h01013, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0},
        '{OpWalk, 20'h00013, 2'd0, 1'b0, 20'h00000, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OpILook, 20'h00013, 2'd0, 1'b1, 20'h01013, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0}
    };

    pageTableMem #(.SEED(32'hc207_0183), .ROOT(22'd1)) ptMem (
        .clk(clk), .rst(rst), .memReq(memReq), .memAddr(memAddr),
        .memRespValid(memRespValid), .memRespData(memRespData)
    );

    mmuTop uut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkTranslation(input string side, input logic hit, input logic [19:0] ppn,
                                    input logic [2:0] rwx, input logic user, input logic sup,
                                    input logic pf, input logic af, input Step s);
        compareValue({side, "Hit"}, 32'(hit), 32'(s.hit));
        if (s.hit) begin
            compareValue({side, "Ppn"}, 32'(ppn), 32'(s.ppn));
            compareValue({side, "Rwx"}, 32'(rwx), 32'(s.rwx));
            compareValue({side, "User"}, 32'(user), 32'(s.user));
            compareValue({side, "Super"}, 32'(sup), 32'(s.sup));
            compareValue({side, "PageFault"}, 32'(pf), 32'(s.pf));
            compareValue({side, "AccessFault"}, 32'(af), 32'(s.af));
        end
    endtask

    task automatic applyLookup(input Step s, input bit dataSide);
        @(negedge clk);
        if (dataSide) begin
            dValid = 2'b11;
            dVpn = {s.vpn, s.vpn};     // both AGU ports see the same page.
        end else begin
            iValid = 1'b1;
            iVpn = s.vpn;
        end
        #2;
        if (dataSide) begin
            for (int p = 0; p < 2; p++)
                checkTranslation($sformatf("d%0d", p), dHit[p], dPpn[p], dRwx[p], dUser[p],
                                 dSuper[p], dPageFault[p], dAccessFault[p], s);
        end else begin
            checkTranslation("i", iHit, iPpn, iRwx, iUser, iSuper, iPageFault, iAccessFault, s);
        end
        @(negedge clk);
        iValid = 1'b0;
        dValid = 2'b00;
    endtask

    task automatic applyWalk(input Step s, input bit withClear);
        int cycles;
        bit done;
        cycles = 0;
        done = 1'b0;
        @(negedge clk);
        while (walkBusy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (walkBusy) begin
            errors++;
            $display("walker stayed busy too long before a new request");
            return;
        end
        walkReqValid = 1'b1;
        walkReqVpn = s.vpn;
        walkReqId = s.id;
        @(negedge clk);
        walkReqValid = 1'b0;
        if (withClear) begin
            compareValue("walkBusy", 32'(walkBusy), 32'd1);
            clear = 1'b1;              // fence lands while the walk is in flight.
        end
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            clear = 1'b0;
            if (walkDoneValid)
                done = 1'b1;
            else
                cycles++;
        end
        if (!done) begin
            errors++;
            $display("walk of vpn 0x%h never finished", s.vpn);
            return;
        end
        compareValue("walkDoneId", 32'(walkDoneId), 32'(s.id));
        compareValue("walkDonePageFault", 32'(walkDonePageFault), 32'(s.pf));
        compareValue("walkDoneAccessFault", 32'(walkDoneAccessFault), 32'(s.af));
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        rst = 1'b1;
        clear = 1'b0;
        rootPpn = 22'd1;
        walkReqValid = 1'b0;
        walkReqVpn = '0;
        walkReqId = '0;
        iValid = 1'b0;
        iVpn = '0;
        dValid = 2'b00;
        dVpn = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compareValue("memReq", 32'(memReq), 32'd0);
        compareValue("walkBusy", 32'(walkBusy), 32'd0);
        compareValue("walkDoneValid", 32'(walkDoneValid), 32'd0);

        foreach (steps[n]) begin
            case (steps[n].op)
                OpWalk: applyWalk(steps[n], 1'b0);
                OpClearWalk: applyWalk(steps[n], 1'b1);
                OpILook: applyLookup(steps[n], 1'b0);
                OpDLook: applyLookup(steps[n], 1'b1);
                default: begin
                    @(negedge clk);
                    clear = 1'b1;
                    @(negedge clk);
                    clear = 1'b0;
                end
            endcase
        end

        $display("mmuTb done: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
src/mmuPkg.sv
src/pageWalkBus.sv
src/tlb.sv
src/pageWalker.sv
src/mmuTop.sv
testbench/pageTableMem.sv
testbench/mmuTb.sv

// ==== Makefile ====
# Verilator simulation of the MMU testbench.

VERILATOR ?= verilator
TOP       ?= mmuTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv) $(wildcard testbench/*.sv) $(wildcard include/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
